// File: design/simmem_free_slot_finder.sv
// Slot occupancy bits and lowest-free-slot priority search
`timescale 1ns/1ps

module simmem_free_slot_finder (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   reserve_ready_i,
  output simmem_pkg::addr_t      free_addr_o,
  output logic                   reserve_valid_o,
  output logic                   reserve_fire_o,

  input  simmem_pkg::slot_mask_t release_onehot_i
);

  simmem_pkg::slot_mask_t occupied_d;
  simmem_pkg::slot_mask_t occupied_q;
  simmem_pkg::slot_mask_t reserve_mask;

  // Lowest clear bit wins, scan from the top so the last hit stays
  always_comb begin : free_search
    free_addr_o = '0;
    for (int i = simmem_pkg::Capacity - 1; i >= 0; i--) begin
      if (!occupied_q[i]) begin
        free_addr_o = simmem_pkg::addr_t'(i);
      end
    end
  end

  // Any free slot left
  assign reserve_valid_o = ~&occupied_q;
  assign reserve_fire_o  = reserve_valid_o & reserve_ready_i;

  always_comb begin : reserve_onehot
    reserve_mask = '0;
    reserve_mask[free_addr_o] = reserve_fire_o;
  end

  // A reserved slot is free and a released one is occupied, so the masks never overlap
  assign occupied_d = (occupied_q | reserve_mask) & ~release_onehot_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      occupied_q <= '0;
    end else begin
      occupied_q <= occupied_d;
    end
  end

endmodule

// File: design/simmem_id_list.sv
// Head, fill and tail pointers and counters of one identifier's linked list
`timescale 1ns/1ps

module simmem_id_list #(
  parameter int unsigned Id = 0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  reserve_i,
  input  simmem_pkg::addr_t     free_addr_i,
  input  logic                  write_i,
  input  logic                  pop_i,

  // Links read behind the fill and tail pointers
  input  simmem_pkg::addr_t     next_fill_i,
  input  simmem_pkg::addr_t     next_tail_i,

  output logic                  link_we_o,
  output simmem_pkg::addr_t     link_waddr_o,
  output simmem_pkg::addr_t     link_wdata_o,
  output simmem_pkg::addr_t     fill_addr_o,
  output logic                  reserved_o,

  simmem_release_if.list        lst
);

  // Head is the newest reservation, fill the oldest unfilled one, tail the oldest entry
  simmem_pkg::addr_t  head_d;
  simmem_pkg::addr_t  head_q;
  simmem_pkg::addr_t  fill_d;
  simmem_pkg::addr_t  fill_q;
  simmem_pkg::addr_t  tail_d;
  simmem_pkg::addr_t  tail_q;

  simmem_pkg::count_t reserved_d;
  simmem_pkg::count_t reserved_q;
  simmem_pkg::count_t stored_d;
  simmem_pkg::count_t stored_q;
  simmem_pkg::count_t reserved_left;

  logic in_flight_d;
  logic in_flight_q;
  logic list_empty;

  assign list_empty    = (reserved_q == '0) && (stored_q == '0);
  assign reserved_left = reserved_q - simmem_pkg::count_t'(write_i);

  ////////////////////////////////////////////////////////////////////////////
  // Pointer updates
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : next_pointers
    head_d = head_q;
    fill_d = fill_q;
    tail_d = tail_q;

    if (reserve_i) begin
      head_d = free_addr_i;
    end

    // No open reservation after this cycle's write, the new slot is next to fill
    if (reserve_i && reserved_left == '0) begin
      fill_d = free_addr_i;
    end else if (write_i) begin
      fill_d = next_fill_i;
    end

    // List runs empty this cycle, so the new slot becomes the oldest entry
    if (reserve_i && reserved_q == '0 && stored_q == simmem_pkg::count_t'(pop_i)) begin
      tail_d = free_addr_i;
    end else if (pop_i) begin
      tail_d = next_tail_i;
    end
  end

  // Chain the new slot behind the current head
  assign link_we_o    = reserve_i && !list_empty;
  assign link_waddr_o = link_we_o ? head_q : '0;
  assign link_wdata_o = link_we_o ? free_addr_i : '0;

  // Zero when idle so the top level can OR all lists
  assign fill_addr_o  = write_i ? fill_q : '0;
  assign reserved_o   = (reserved_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////////////////////

  assign reserved_d = reserved_q + simmem_pkg::count_t'(reserve_i)
                    - simmem_pkg::count_t'(write_i);
  assign stored_d   = stored_q + simmem_pkg::count_t'(write_i)
                    - simmem_pkg::count_t'(pop_i);

  // Set on load into the output register, cleared at handover
  assign in_flight_d = pop_i ? 1'b1 : (lst.done[Id] ? 1'b0 : in_flight_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q      <= '0;
      fill_q      <= '0;
      tail_q      <= '0;
      reserved_q  <= '0;
      stored_q    <= '0;
      in_flight_q <= 1'b0;
    end else begin
      head_q      <= head_d;
      fill_q      <= fill_d;
      tail_q      <= tail_d;
      reserved_q  <= reserved_d;
      stored_q    <= stored_d;
      in_flight_q <= in_flight_d;
    end
  end

  assign lst.tail[Id]        = tail_q;
  assign lst.has_message[Id] = (stored_q != '0);
  assign lst.in_flight[Id]   = in_flight_q;

endmodule

// File: design/simmem_link_ram.sv
// Flop memory with one write port and two combinational read ports
`timescale 1ns/1ps

module simmem_link_ram #(
  parameter int unsigned Width = 16,
  parameter int unsigned Depth = 16
) (
  input  logic              clk_i,

  // Write port
  input  logic              we_i,
  input  simmem_pkg::addr_t waddr_i,
  input  logic [Width-1:0]  wdata_i,

  // Read port a
  input  simmem_pkg::addr_t raddr_a_i,
  output logic [Width-1:0]  rdata_a_o,

  // Read port b
  input  simmem_pkg::addr_t raddr_b_i,
  output logic [Width-1:0]  rdata_b_o
);

  logic [Width-1:0] mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // Reads see the old word in the write cycle
  assign rdata_a_o = mem_q[raddr_a_i];
  assign rdata_b_o = mem_q[raddr_b_i];

endmodule

// File: design/simmem_pkg.sv
// Bank sizes, derived widths and shared types of the response bank
package simmem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Message format
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned MsgWidth = 16;

  // Identifier sits in the low bits of each message
  localparam int unsigned IdWidth = 2;
  localparam int unsigned NumIds  = 2 ** IdWidth;

  ////////////////////////////////////////////////////////////////////////////
  // Slot memory
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned Capacity  = 16;
  localparam int unsigned AddrWidth = $clog2(Capacity);

  // Needs to hold a count equal to the full capacity
  localparam int unsigned CountWidth = $clog2(Capacity + 1);

  typedef logic [AddrWidth-1:0]  addr_t;
  typedef logic [MsgWidth-1:0]   msg_t;
  typedef logic [IdWidth-1:0]    id_t;
  typedef logic [CountWidth-1:0] count_t;
  typedef logic [Capacity-1:0]   slot_mask_t;

endpackage

// File: design/simmem_release_arbiter.sv
// Eligible-identifier choice, output register and released-slot pulse
`timescale 1ns/1ps

module simmem_release_arbiter (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  simmem_pkg::slot_mask_t release_en_i,
  input  logic                   out_ready_i,

  // Message memory read
  input  simmem_pkg::msg_t       msg_rdata_i,
  output simmem_pkg::addr_t      msg_raddr_o,

  output simmem_pkg::msg_t       data_o,
  output logic                   out_valid_o,
  output simmem_pkg::slot_mask_t released_onehot_o,

  simmem_release_if.arbiter      arb
);

  logic [simmem_pkg::NumIds-1:0] eligible;
  simmem_pkg::id_t               chosen_id;

  logic handover;
  logic can_load;
  logic load;

  logic              valid_q;
  simmem_pkg::msg_t  data_q;
  simmem_pkg::addr_t slot_q;
  simmem_pkg::id_t   owner_q;

  ////////////////////////////////////////////////////////////////////////////
  // Identifier choice
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < simmem_pkg::NumIds; i++) begin : g_per_id
    assign eligible[i] = arb.has_message[i] && !arb.in_flight[i] &&
                         release_en_i[arb.tail[i]];
    assign arb.pop[i]  = load && (chosen_id == simmem_pkg::id_t'(i));
    assign arb.done[i] = handover && (owner_q == simmem_pkg::id_t'(i));
  end

  // Lowest eligible identifier
  always_comb begin : pick_lowest
    chosen_id = '0;
    for (int i = simmem_pkg::NumIds - 1; i >= 0; i--) begin
      if (eligible[i]) begin
        chosen_id = simmem_pkg::id_t'(i);
      end
    end
  end

  assign msg_raddr_o = arb.tail[chosen_id];

  ////////////////////////////////////////////////////////////////////////////
  // Output register
  ////////////////////////////////////////////////////////////////////////////

  assign handover = valid_q && out_ready_i;
  assign can_load = !valid_q || out_ready_i;
  assign load     = can_load && (|eligible);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (handover) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q  <= msg_rdata_i;
      slot_q  <= msg_raddr_o;
      owner_q <= chosen_id;
    end
  end

  assign data_o      = data_q;
  assign out_valid_o = valid_q;

  // Slot goes back to the finder in the handover cycle
  always_comb begin : release_pulse
    released_onehot_o = '0;
    released_onehot_o[slot_q] = handover;
  end

endmodule

// File: design/simmem_release_if.sv
// Release interface between the per-identifier lists and the release arbiter
`timescale 1ns/1ps

interface simmem_release_if;

  // Oldest list entry of each identifier
  simmem_pkg::addr_t tail [simmem_pkg::NumIds];

  // At least one stored message behind the tail
  logic has_message [simmem_pkg::NumIds];

  // Message of this identifier held in the output register
  logic in_flight [simmem_pkg::NumIds];

  // Output register loads from this identifier
  logic pop [simmem_pkg::NumIds];

  // Output register hands over this identifier's message
  logic done [simmem_pkg::NumIds];

  modport list (
    output tail,
    output has_message,
    output in_flight,
    input  done
  );

  modport arbiter (
    input  tail,
    input  has_message,
    input  in_flight,
    output pop,
    output done
  );

endinterface

// File: design/simmem_resp_bank.sv
// Response bank top level with lists, slot memories, finder and release arbiter
`timescale 1ns/1ps

module simmem_resp_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Reservation side
  input  simmem_pkg::id_t        reserve_id_i,
  input  logic                   reserve_ready_i,
  output logic                   reserve_valid_o,
  output simmem_pkg::addr_t      new_reserved_addr_o,

  // Input side
  input  simmem_pkg::msg_t       data_i,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,

  // Output side
  output simmem_pkg::msg_t       data_o,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,

  input  simmem_pkg::slot_mask_t release_en_i,
  output simmem_pkg::slot_mask_t released_onehot_o
);

  simmem_pkg::id_t               in_id;
  logic                          in_fire;
  logic                          reserve_fire;
  logic [simmem_pkg::NumIds-1:0] reserved;
  logic [simmem_pkg::NumIds-1:0] link_we_id;
  simmem_pkg::addr_t             link_waddr_id [simmem_pkg::NumIds];
  simmem_pkg::addr_t             link_wdata_id [simmem_pkg::NumIds];
  simmem_pkg::addr_t             fill_addr_id  [simmem_pkg::NumIds];

  logic              link_we;
  simmem_pkg::addr_t link_waddr;
  simmem_pkg::addr_t link_wdata;
  simmem_pkg::addr_t fill_addr;
  simmem_pkg::addr_t next_fill;
  simmem_pkg::addr_t next_tail;
  simmem_pkg::addr_t msg_raddr;
  simmem_pkg::msg_t  msg_rdata;

  simmem_release_if u_release_if ();

  assign in_id      = data_i[simmem_pkg::IdWidth-1:0];
  assign in_ready_o = in_valid_i && reserved[in_id];
  assign in_fire    = in_valid_i && in_ready_o;

  simmem_free_slot_finder u_free_slot_finder (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .reserve_ready_i  (reserve_ready_i),
    .free_addr_o      (new_reserved_addr_o),
    .reserve_valid_o  (reserve_valid_o),
    .reserve_fire_o   (reserve_fire),
    .release_onehot_i (released_onehot_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Per-identifier lists
  ////////////////////////////////////////////////////////////////////////////

  for (genvar g = 0; g < simmem_pkg::NumIds; g++) begin : g_list
    simmem_id_list #(
      .Id (g)
    ) u_id_list (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .reserve_i    (reserve_fire && (reserve_id_i == simmem_pkg::id_t'(g))),
      .free_addr_i  (new_reserved_addr_o),
      .write_i      (in_fire && (in_id == simmem_pkg::id_t'(g))),
      .pop_i        (u_release_if.pop[g]),
      .next_fill_i  (next_fill),
      .next_tail_i  (next_tail),
      .link_we_o    (link_we_id[g]),
      .link_waddr_o (link_waddr_id[g]),
      .link_wdata_o (link_wdata_id[g]),
      .fill_addr_o  (fill_addr_id[g]),
      .reserved_o   (reserved[g]),
      .lst          (u_release_if.list)
    );
  end

  // At most one list drives each write port, the others send zeros
  always_comb begin : merge_write_ports
    link_we    = 1'b0;
    link_waddr = '0;
    link_wdata = '0;
    fill_addr  = '0;
    for (int i = 0; i < simmem_pkg::NumIds; i++) begin
      link_we    |= link_we_id[i];
      link_waddr |= link_waddr_id[i];
      link_wdata |= link_wdata_id[i];
      fill_addr  |= fill_addr_id[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slot memories and release
  ////////////////////////////////////////////////////////////////////////////

  simmem_link_ram #(
    .Width (simmem_pkg::MsgWidth),
    .Depth (simmem_pkg::Capacity)
  ) u_msg_ram (
    .clk_i     (clk_i),
    .we_i      (in_fire),
    .waddr_i   (fill_addr),
    .wdata_i   (data_i),
    .raddr_a_i (msg_raddr),
    .rdata_a_o (msg_rdata),
    .raddr_b_i (msg_raddr),
    .rdata_b_o ()
  );

  // Port a follows the fill pointer, port b the tail being popped
  simmem_link_ram #(
    .Width (simmem_pkg::AddrWidth),
    .Depth (simmem_pkg::Capacity)
  ) u_next_ram (
    .clk_i     (clk_i),
    .we_i      (link_we),
    .waddr_i   (link_waddr),
    .wdata_i   (link_wdata),
    .raddr_a_i (fill_addr),
    .rdata_a_o (next_fill),
    .raddr_b_i (msg_raddr),
    .rdata_b_o (next_tail)
  );

  simmem_release_arbiter u_release_arbiter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .release_en_i      (release_en_i),
    .out_ready_i       (out_ready_i),
    .msg_rdata_i       (msg_rdata),
    .msg_raddr_o       (msg_raddr),
    .data_o            (data_o),
    .out_valid_o       (out_valid_o),
    .released_onehot_o (released_onehot_o),
    .arb               (u_release_if.arbiter)
  );

endmodule

// File: files.f
design/simmem_pkg.sv
design/simmem_release_if.sv
design/simmem_free_slot_finder.sv
design/simmem_link_ram.sv
design/simmem_id_list.sv
design/simmem_release_arbiter.sv
design/simmem_resp_bank.sv
testbench/simmem_resp_bank_sva.sv
testbench/tb_simmem_resp_bank.sv

// File: testbench/simmem_resp_bank_sva.sv
// Concurrent assertions on the response bank ports and their bind to the top level
`timescale 1ns/1ps

module simmem_resp_bank_sva (
  input logic                   clk_i,
  input logic                   rst_ni,
  input simmem_pkg::id_t        reserve_id_i,
  input logic                   reserve_ready_i,
  input logic                   reserve_valid_o,
  input simmem_pkg::addr_t      new_reserved_addr_o,
  input simmem_pkg::msg_t       data_i,
  input logic                   in_valid_i,
  input logic                   in_ready_o,
  input simmem_pkg::msg_t       data_o,
  input logic                   out_valid_o,
  input logic                   out_ready_i,
  input simmem_pkg::slot_mask_t released_onehot_o
);

  logic                   reserve_hs;
  logic                   input_hs;
  simmem_pkg::id_t        input_id;
  simmem_pkg::slot_mask_t reserved_slots_q;
  simmem_pkg::count_t     open_cnt_q [simmem_pkg::NumIds];

  assign reserve_hs = reserve_valid_o && reserve_ready_i;
  assign input_hs   = in_valid_i && in_ready_o;
  assign input_id   = data_i[simmem_pkg::IdWidth-1:0];

  // Slots reserved at the ports and not yet released
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reserved_slots_q <= '0;
    end else begin
      for (int i = 0; i < simmem_pkg::Capacity; i++) begin
        if (released_onehot_o[i]) begin
          reserved_slots_q[i] <= 1'b0;
        end else if (reserve_hs && new_reserved_addr_o == simmem_pkg::addr_t'(i)) begin
          reserved_slots_q[i] <= 1'b1;
        end
      end
    end
  end

  // Open reservations per identifier
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < simmem_pkg::NumIds; i++) begin
        open_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < simmem_pkg::NumIds; i++) begin
        open_cnt_q[i] <= open_cnt_q[i]
                         + simmem_pkg::count_t'(reserve_hs && reserve_id_i == simmem_pkg::id_t'(i))
                         - simmem_pkg::count_t'(input_hs && input_id == simmem_pkg::id_t'(i));
      end
    end
  end

  // At most one slot freed per cycle
  released_onehot_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(released_onehot_o))
    else $error("released_onehot_o has more than one bit set");

  // Output holds under back-pressure
  output_hold_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(data_o))
    else $error("data_o or out_valid_o changed while out_ready_i was low");

  // Slot release only with a handover and only for a reserved slot
  release_handover_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    released_onehot_o != '0 |->
      out_valid_o && out_ready_i && (released_onehot_o & ~reserved_slots_q) == '0)
    else $error("slot released without a handover or without a reservation");

  // Input taken only with a valid message and an open reservation of its identifier
  input_ready_check: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_ready_o |-> in_valid_i && open_cnt_q[input_id] != '0)
    else $error("in_ready_o high without in_valid_i or an open reservation");

endmodule

bind simmem_resp_bank simmem_resp_bank_sva u_resp_bank_sva (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .reserve_id_i        (reserve_id_i),
  .reserve_ready_i     (reserve_ready_i),
  .reserve_valid_o     (reserve_valid_o),
  .new_reserved_addr_o (new_reserved_addr_o),
  .data_i              (data_i),
  .in_valid_i          (in_valid_i),
  .in_ready_o          (in_ready_o),
  .data_o              (data_o),
  .out_valid_o         (out_valid_o),
  .out_ready_i         (out_ready_i),
  .released_onehot_o   (released_onehot_o)
);

// File: testbench/tb_simmem_resp_bank.sv
// Testbench for the response bank with stimulus table, reference model and checks
`timescale 1ns/1ps

module tb_simmem_resp_bank;

  localparam int OpReserve = 0;
  localparam int OpSend    = 1;
  localparam int OpDrain   = 2;
  localparam int MaxRows   = 48;
  // Expected value of a reservation when no slot is free
  localparam int Full      = 16;

  localparam simmem_pkg::slot_mask_t AllOn   = 16'hffff;
  localparam simmem_pkg::slot_mask_t NoSlot0 = 16'hfffe;

  logic                   clk_i;
  logic                   rst_ni;
  simmem_pkg::id_t        reserve_id_i;
  logic                   reserve_ready_i;
  logic                   reserve_valid_o;
  simmem_pkg::addr_t      new_reserved_addr_o;
  simmem_pkg::msg_t       data_i;
  logic                   in_valid_i;
  logic                   in_ready_o;
  simmem_pkg::msg_t       data_o;
  logic                   out_valid_o;
  logic                   out_ready_i;
  simmem_pkg::slot_mask_t release_en_i;
  simmem_pkg::slot_mask_t released_onehot_o;

  // Stimulus table
  int                     row_op    [MaxRows];
  int                     row_id    [MaxRows];
  simmem_pkg::slot_mask_t row_mask  [MaxRows];
  logic [3:0]             row_ready [MaxRows];
  int                     row_exp   [MaxRows];
  int                     n_rows = 0;

  // Reference model of occupancy, reserved slots per identifier and payload per slot
  logic [15:0]      occ = '0;
  int               rsv_slot  [4][16];
  int               rsv_cnt   [4] = '{default: 0};
  int               fill_cnt  [4] = '{default: 0};
  int               pop_cnt   [4] = '{default: 0};
  simmem_pkg::msg_t slot_data [16];

  logic [31:0] lcg_state = 32'd46;
  int          err_cnt = 0;
  int          rows_failed = 0;
  int          cycle_cnt = 0;
  int          cycle_limit;

  simmem_resp_bank u_simmem_resp_bank (.*);

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic int lowest_free();
    int addr;
    addr = Full;
    for (int i = 15; i >= 0; i--) begin
      if (!occ[i]) begin
        addr = i;
      end
    end
    return addr;
  endfunction

  function automatic string op_name(input int op);
    if (op == OpReserve) begin
      return "reserve";
    end else if (op == OpSend) begin
      return "send";
    end
    return "drain";
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    err_cnt++;
  endtask

  task automatic report_error(input string what);
    $display("error: %s", what);
    err_cnt++;
  endtask

  task automatic add_row(input int op, input int id, input simmem_pkg::slot_mask_t mask,
                         input logic [3:0] ready, input int exp);
    row_op[n_rows]    = op;
    row_id[n_rows]    = id;
    row_mask[n_rows]  = mask;
    row_ready[n_rows] = ready;
    row_exp[n_rows]   = exp;
    n_rows++;
  endtask

  task automatic build_table();
    // Unreserved identifier is refused
    add_row(OpSend, 1, AllOn, 4'h0, 0);
    // Slots handed out lowest first to the identifiers in turn
    for (int i = 0; i < 16; i++) begin
      add_row(OpReserve, i % 4, AllOn, 4'h0, i);
    end
    add_row(OpReserve, 0, AllOn, 4'h0, Full);
    // Slot 0 withheld by its release bit
    add_row(OpSend, 0, NoSlot0, 4'h0, 1);
    add_row(OpSend, 1, NoSlot0, 4'h0, 1);
    add_row(OpSend, 1, NoSlot0, 4'h0, 1);
    add_row(OpSend, 2, NoSlot0, 4'h0, 1);
    add_row(OpSend, 0, NoSlot0, 4'h0, 1);
    add_row(OpDrain, 1, NoSlot0, 4'b1000, 0);
    add_row(OpDrain, 2, NoSlot0, 4'b0001, 0);
    add_row(OpDrain, 1, NoSlot0, 4'b0010, 0);
    add_row(OpDrain, 0, AllOn, 4'b0001, 0);
    add_row(OpDrain, 0, AllOn, 4'b0100, 0);
    // Reservation order per identifier with the lowest identifier first
    add_row(OpSend, 3, AllOn, 4'h0, 1);
    add_row(OpSend, 3, AllOn, 4'h0, 1);
    add_row(OpSend, 2, AllOn, 4'h0, 1);
    add_row(OpSend, 0, AllOn, 4'h0, 1);
    add_row(OpDrain, 3, AllOn, 4'b0001, 0);
    add_row(OpDrain, 0, AllOn, 4'b0001, 0);
    add_row(OpDrain, 2, AllOn, 4'b0001, 0);
    add_row(OpDrain, 3, AllOn, 4'b0001, 0);
    // Freed slots come back lowest first
    add_row(OpReserve, 1, AllOn, 4'h0, 0);
    add_row(OpReserve, 2, AllOn, 4'h0, 1);
    add_row(OpSend, 2, AllOn, 4'h0, 1);
    add_row(OpDrain, 2, AllOn, 4'b0001, 0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Operations that start and end at a falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic reserve_slot(input int id, input int exp);
    int model_addr;
    model_addr = lowest_free();
    reserve_id_i    = simmem_pkg::id_t'(id);
    reserve_ready_i = 1'b1;
    #1;
    if (model_addr != exp) begin
      report_error("reference model and table disagree on the reserved slot");
    end
    if (exp == Full) begin
      if (reserve_valid_o !== 1'b0) begin
        report_mismatch("reserve_valid_o", reserve_valid_o, 1'b0);
      end
    end else begin
      if (reserve_valid_o !== 1'b1) begin
        report_mismatch("reserve_valid_o", reserve_valid_o, 1'b1);
      end
      if (new_reserved_addr_o !== simmem_pkg::addr_t'(exp)) begin
        report_mismatch("new_reserved_addr_o", new_reserved_addr_o, exp);
      end
      occ[exp] = 1'b1;
      rsv_slot[id][rsv_cnt[id] % 16] = exp;
      rsv_cnt[id]++;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    reserve_ready_i = 1'b0;
  endtask

  task automatic send_message(input int id, input int exp);
    logic [31:0]      rnd;
    simmem_pkg::msg_t payload;
    logic             accept;
    rnd     = lcg_next();
    payload = {rnd[29:16], simmem_pkg::id_t'(id)};
    accept  = (fill_cnt[id] < rsv_cnt[id]);
    if (accept != (exp != 0)) begin
      report_error("reference model and table disagree on in_ready_o");
    end
    data_i     = payload;
    in_valid_i = 1'b1;
    #1;
    if (in_ready_o !== (exp != 0)) begin
      report_mismatch("in_ready_o", in_ready_o, exp);
    end
    if (accept) begin
      slot_data[rsv_slot[id][fill_cnt[id] % 16]] = payload;
      fill_cnt[id]++;
    end
    @(posedge clk_i);
    @(negedge clk_i);
    in_valid_i = 1'b0;
  endtask

  task automatic drain_message(input int id, input logic [3:0] pattern);
    simmem_pkg::slot_mask_t exp_mask;
    int                     slot;
    bit                     done;
    done = 1'b0;
    while (out_valid_o !== 1'b1) begin
      @(negedge clk_i);
    end
    if (pop_cnt[id] >= fill_cnt[id]) begin
      report_error("reference model holds no stored message for this identifier");
    end else begin
      slot     = rsv_slot[id][pop_cnt[id] % 16];
      exp_mask = '0;
      exp_mask[slot] = 1'b1;
      for (int i = 0; i < 4; i++) begin
        if (done) begin
          continue;
        end
        if (!pattern[i]) begin
          // Stall cycle with the output held
          @(negedge clk_i);
          if (out_valid_o !== 1'b1) begin
            report_mismatch("out_valid_o", out_valid_o, 1'b1);
          end
          if (data_o !== slot_data[slot]) begin
            report_mismatch("data_o", data_o, slot_data[slot]);
          end
        end else begin
          out_ready_i = 1'b1;
          #1;
          if (data_o !== slot_data[slot]) begin
            report_mismatch("data_o", data_o, slot_data[slot]);
          end
          if (released_onehot_o !== exp_mask) begin
            report_mismatch("released_onehot_o", released_onehot_o, exp_mask);
          end
          @(posedge clk_i);
          occ[slot] = 1'b0;
          pop_cnt[id]++;
          @(negedge clk_i);
          out_ready_i = 1'b0;
          done = 1'b1;
        end
      end
      if (!done) begin
        report_error("out_ready_i pattern never allowed a handover");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    int errs_before;
    int table_len;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    reserve_id_i    = '0;
    reserve_ready_i = 1'b0;
    data_i          = '0;
    in_valid_i      = 1'b0;
    out_ready_i     = 1'b0;
    release_en_i    = '0;
    build_table();
    table_len = 0;
    for (int r = 0; r < n_rows; r++) begin
      table_len += (row_op[r] == OpDrain) ? 8 : 2;
    end
    cycle_limit = 2 * table_len + 200;

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    // State right after reset
    if (out_valid_o !== 1'b0 || in_ready_o !== 1'b0 || released_onehot_o !== '0) begin
      report_error("outputs not idle after reset");
    end
    if (reserve_valid_o !== 1'b1) begin
      report_mismatch("reserve_valid_o", reserve_valid_o, 1'b1);
    end
    @(negedge clk_i);

    for (int r = 0; r < n_rows; r++) begin
      errs_before  = err_cnt;
      release_en_i = row_mask[r];
      if (row_op[r] == OpReserve) begin
        reserve_slot(row_id[r], row_exp[r]);
      end else if (row_op[r] == OpSend) begin
        send_message(row_id[r], row_exp[r]);
      end else begin
        drain_message(row_id[r], row_ready[r]);
      end
      if (err_cnt != errs_before) begin
        rows_failed++;
      end
      $display("row %0d %s id %0d: %s", r, op_name(row_op[r]), row_id[r],
               (err_cnt == errs_before) ? "ok" : "FAIL");
    end

    $display("rows %0d, rows failed %0d, errors %0d", n_rows, rows_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
